// File: tb.f
verilog/fscpu_pkg.sv
verilog/step_table_ram.sv
verilog/motor_seq.sv
verilog/fscpu.sv
tests/tb_clkgen.sv
tests/fscpu_props.sv
tests/tb_fscpu.sv

// File: run.sh
#!/bin/bash
# build and run the fscpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_fscpu -o sim_tb \
	&& { ./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log; } \
	|| { echo "build or run error"; exit 1; }

! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log && exit 0 || exit 1

// File: tests/tb_fscpu.sv
`timescale 1ns/1ps

// driver model, busy follows a start and position moves when it ends
module motor_model (
	input  logic                   clk,
	input  logic                   resetn,
	input  fscpu_pkg::motor_cmd_t  cmd,
	output fscpu_pkg::motor_stat_t stat
);
	int          delay;
	int          hold;
	logic        pend_dir;
	logic [31:0] pend_step;

	initial stat = '0;

	always @(posedge clk) begin
		if (!resetn) begin
			stat  <= '0;
			delay <= 0;
			hold  <= 0;
		end else if (cmd.start) begin
			delay     <= 2;
			pend_dir  <= cmd.dir;
			pend_step <= cmd.step;
		end else if (delay > 0) begin
			delay <= delay - 1;
			if (delay == 1) begin
				stat.busy <= 1'b1;
				hold      <= int'(pend_step % 32'd16) + 1;
			end
		end else if (hold > 0) begin
			hold <= hold - 1;
			if (hold == 1) begin
				stat.busy     <= 1'b0;
				stat.position <= pend_dir ? stat.position - pend_step : stat.position + pend_step;
			end
		end
	end

endmodule

module tb_fscpu;
	import fscpu_pkg::*;

	localparam int clk_ns    = 40;
	localparam int wd_cycles = 20000;

	logic clk;
	logic resetn;
	logic bpm_init, bpm_wr_en, bam_init, bam_wr_en;
	logic [31:0] bpm_data, bam_data;
	logic [12:0] bpm_size, bam_size;
	logic req_en, req_done;
	logic [31:0] req_cmd;
	logic [127:0] req_param;
	logic x_ana_done, y_ana_done;
	img_edge_t l_edge, r_edge, x_edge, y_edge;
	motor_stat_t ml_stat, mr_stat, mx_stat, my_stat;
	motor_cmd_t ml_cmd, mr_cmd, mx_cmd, my_cmd;

	int errors = 0;
	int test_err0;
	int ml_starts, mr_starts, mx_starts, my_starts, mr_stops;
	motor_cmd_t ml_last, mx_last, my_last;
	logic ml_busy_q, ml_busy_fell;
	logic check_steps = 1'b0;
	logic [11:0] cur_dst;
	logic [31:0] exp_tbl [4096];
	int exp_size;

	tb_clkgen u_clkgen (.clk(clk), .resetn(resetn));

	fscpu DUT (.*);

	motor_model u_ml (.clk(clk), .resetn(resetn), .cmd(ml_cmd), .stat(ml_stat));
	motor_model u_mr (.clk(clk), .resetn(resetn), .cmd(mr_cmd), .stat(mr_stat));
	motor_model u_mx (.clk(clk), .resetn(resetn), .cmd(mx_cmd), .stat(mx_stat));
	motor_model u_my (.clk(clk), .resetn(resetn), .cmd(my_cmd), .stat(my_stat));

	// cameras see the motor positions directly
	assign l_edge = '{valid: 1'b1, pos: ml_stat.position[11:0]};
	assign r_edge = '{valid: 1'b1, pos: mr_stat.position[11:0]};
	assign x_edge = '{valid: 1'b1, pos: mx_stat.position[11:0]};
	assign y_edge = '{valid: 1'b1, pos: my_stat.position[11:0]};

	// signed distance still to travel, target minus measured edge
	function automatic int edge_error(logic [11:0] pos, logic [11:0] dst);
		return int'(dst) - int'(pos);
	endfunction

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic require(logic cond, string what);
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic send_req(logic [31:0] cmd, logic [31:0] p0, logic [31:0] p1,
		logic [31:0] p2, logic [31:0] p3);
		ml_starts = 0;
		mr_starts = 0;
		mx_starts = 0;
		my_starts = 0;
		mr_stops = 0;
		ml_busy_fell = 1'b0;
		req_cmd = cmd;
		req_param = {p3, p2, p1, p0};
		req_en = 1'b1;
		@(negedge clk);
		req_en = 1'b0;
	endtask

	task automatic wait_done(int max_cycles);
		int n;
		n = 0;
		while (!req_done && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		require(req_done, "req_done never rose for the running command");
	endtask

	task automatic load_push_table(int n);
		bpm_init = 1'b1;
		@(negedge clk);
		bpm_init = 1'b0;
		for (int i = 0; i < n; i++) begin
			// entries never overshoot, so the loop converges
			exp_tbl[i] = 32'(i) - ($urandom % 32'(i / 2 + 1));
			bpm_data = exp_tbl[i];
			bpm_wr_en = 1'b1;
			@(negedge clk);
		end
		bpm_wr_en = 1'b0;
		exp_size = n;
		@(negedge clk);
	endtask

	task automatic finish_test(int num, string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_err0);
		test_err0 = errors;
	endtask

	always @(negedge clk) begin
		int err;
		int mag;
		int idx;
		if (ml_cmd.start) begin
			ml_starts++;
			ml_last = ml_cmd;
		end
		if (mx_cmd.start) begin
			mx_starts++;
			mx_last = mx_cmd;
		end
		if (my_cmd.start) begin
			my_starts++;
			my_last = my_cmd;
		end
		if (mr_cmd.stop) mr_stops++;
		if (ml_busy_q && !ml_stat.busy) ml_busy_fell = 1'b1;
		ml_busy_q = ml_stat.busy;
		if (mr_cmd.start) begin
			mr_starts++;
			if (check_steps) begin
				err = edge_error(r_edge.pos, cur_dst);
				mag = (err < 0) ? -err : err;
				idx = (mag < exp_size) ? mag : exp_size - 1;
				compare_value("mr_cmd.step", mr_cmd.step, exp_tbl[idx]);
				compare_value("mr_cmd.dir", 32'(mr_cmd.dir), 32'(err < 0));
			end
		end
	end

	// one frame pulse on both cameras every 16 cycles
	initial begin
		x_ana_done = 1'b0;
		y_ana_done = 1'b0;
		forever begin
			repeat (15) @(negedge clk);
			x_ana_done = 1'b1;
			y_ana_done = 1'b1;
			@(negedge clk);
			x_ana_done = 1'b0;
			y_ana_done = 1'b0;
		end
	end

	initial begin
		#(wd_cycles * clk_ns * 1ns);
		$display("watchdog expired before the tests completed");
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] p0, p1, p2, p3;
		int total;
		void'($urandom(32'h11092828));
		bpm_init = 1'b0;
		bpm_wr_en = 1'b0;
		bpm_data = '0;
		bam_init = 1'b0;
		bam_wr_en = 1'b0;
		bam_data = '0;
		req_en = 1'b0;
		req_cmd = '0;
		req_param = '0;
		ml_busy_q = 1'b0;
		exp_size = 0;
		test_err0 = 0;
		wait (resetn);
		@(negedge clk);

		compare_value("req_done", 32'(req_done), 32'd0);
		require(ml_starts + mr_starts + mx_starts + my_starts == 0,
			"a motor started out of reset");
		send_req(32'(cmd_config), 32'd1, 0, 0, 0);
		repeat (10) @(negedge clk);
		send_req(32'd9, 0, 0, 0, 0);
		repeat (10) @(negedge clk);
		compare_value("req_done", 32'(req_done), 32'd0);
		require(ml_starts + mr_starts + mx_starts + my_starts == 0,
			"a motor started without a move command");
		finish_test(1, "reset and config");

		p0 = {29'd0, 1'b0, $urandom_range(1, 0) == 1, 1'b0};
		p1 = $urandom;
		p2 = $urandom % 200 + 1;
		send_req(32'(cmd_lft), p0, p1, p2, 0);
		wait_done(500);
		compare_value("ml starts", 32'(ml_starts), 32'd1);
		compare_value("ml_cmd.step", ml_last.step, p2);
		compare_value("ml_cmd.speed", ml_last.speed, p1);
		compare_value("ml_cmd.dir", 32'(ml_last.dir), 32'(p0[1]));
		require(ml_busy_fell && !ml_stat.busy, "req_done rose while the left motor was busy");
		require(mr_starts + mx_starts + my_starts == 0, "an unselected motor started");
		finish_test(2, "open loop left");

		p2 = $urandom % 100 + 1;
		p3 = $urandom % 100 + 1;
		send_req(32'(cmd_align_both), 0, 32'd50, p2, p3);
		wait_done(500);
		compare_value("mx_cmd.step", mx_last.step, p2);
		compare_value("my_cmd.step", my_last.step, p3);
		require(mx_starts == 1 && my_starts == 1, "align pair did not start once each");
		require(!mx_stat.busy && !my_stat.busy, "req_done rose while an align motor was busy");
		finish_test(3, "align pair");

		load_push_table(7);
		compare_value("bpm_size", 32'(bpm_size), 32'd7);
		bpm_init = 1'b1;
		@(negedge clk);
		bpm_init = 1'b0;
		compare_value("bpm_size", 32'(bpm_size), 32'd0);
		load_push_table(16);
		compare_value("bpm_size", 32'(bpm_size), 32'd16);
		bam_init = 1'b1;
		@(negedge clk);
		bam_init = 1'b0;
		for (int i = 0; i < 5; i++) begin
			bam_data = 32'(i + 1);
			bam_wr_en = 1'b1;
			@(negedge clk);
		end
		bam_wr_en = 1'b0;
		compare_value("bam_size", 32'(bam_size), 32'd5);
		finish_test(4, "table load");

		cur_dst = 12'(60 + $urandom % 60);
		check_steps = 1'b1;
		send_req(32'(cmd_rt), {4'd0, 12'd2, 13'd0, 3'b100}, 32'd80, 0, 32'(cur_dst));
		wait_done(4000);
		check_steps = 1'b0;
		require(mr_starts > 0, "image guided move issued no start");
		require(edge_error(r_edge.pos, cur_dst) >= -2 && edge_error(r_edge.pos, cur_dst) <= 2,
			"right edge outside tolerance at done");
		finish_test(5, "image guided right");

		bpm_init = 1'b1;
		@(negedge clk);
		bpm_init = 1'b0;
		exp_size = 0;
		send_req(32'(cmd_rt), {4'd0, 12'd2, 13'd0, 3'b100}, 32'd80, 0,
			32'(r_edge.pos + 12'd50));
		wait_done(500);
		compare_value("mr stops", 32'(mr_stops), 32'd1);
		compare_value("mr starts", 32'(mr_starts), 32'd0);
		finish_test(6, "empty table");

		total = errors + DUT.u_props.fail_cnt;
		$display("tests 6, check failures %0d, assertion failures %0d",
			errors, DUT.u_props.fail_cnt);
		if (total == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: tests/fscpu_props.sv
`timescale 1ns/1ps

module fscpu_props (
	input logic                   clk,
	input logic                   resetn,
	input logic                   req_en,
	input logic                   req_done,
	input logic [3:0]             dev_bmp,
	input logic [3:0]             done_bmp,
	input fscpu_pkg::motor_cmd_t  ml_cmd,
	input fscpu_pkg::motor_cmd_t  mr_cmd,
	input fscpu_pkg::motor_cmd_t  mx_cmd,
	input fscpu_pkg::motor_cmd_t  my_cmd
);
	import fscpu_pkg::*;

	int         fail_cnt = 0;
	logic [3:0] starts;
	logic [3:0] stops;

	assign starts = {my_cmd.start, mx_cmd.start, mr_cmd.start, ml_cmd.start};
	assign stops  = {my_cmd.stop, mx_cmd.stop, mr_cmd.stop, ml_cmd.stop};

	// done drops right after a new request
	done_clear: assert property (@(posedge clk) disable iff (!resetn) req_en |=> !req_done)
		else begin fail_cnt++; $error("req_done still high after req_en"); end

	done_cause: assert property (@(posedge clk) disable iff (!resetn)
		$rose(req_done) |-> $past(done_bmp == dev_bmp && dev_bmp != 4'd0))
		else begin fail_cnt++; $error("req_done rose before all selected motors were done"); end

	// start is a single cycle pulse
	start_pulse: assert property (@(posedge clk) disable iff (!resetn)
		(starts & $past(starts)) == 4'd0)
		else begin fail_cnt++; $error("motor start held longer than one cycle"); end

	start_sel: assert property (@(posedge clk) disable iff (!resetn) (starts & ~dev_bmp) == 4'd0)
		else begin fail_cnt++; $error("start on a motor outside the device bitmap"); end

	start_stop: assert property (@(posedge clk) disable iff (!resetn) (starts & stops) == 4'd0)
		else begin fail_cnt++; $error("start and stop issued together"); end

endmodule

bind fscpu fscpu_props u_props (.*);

// File: tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic resetn
);
	localparam time half_period = 20ns;

	initial begin
		clk = 1'b0;
		forever begin
			#(half_period) clk = ~clk;
		end
	end

	// reset held for three clock cycles
	initial begin
		resetn = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

// File: verilog/fscpu.sv
`timescale 1ns/1ps

module fscpu (
	input  logic                          clk,
	input  logic                          resetn,

	input  logic                          bpm_init,
	input  logic                          bpm_wr_en,
	input  logic [fscpu_pkg::step_w-1:0]  bpm_data,
	output logic [fscpu_pkg::tbl_aw:0]    bpm_size,

	input  logic                          bam_init,
	input  logic                          bam_wr_en,
	input  logic [fscpu_pkg::step_w-1:0]  bam_data,
	output logic [fscpu_pkg::tbl_aw:0]    bam_size,

	input  logic                          req_en,
	input  logic [31:0]                   req_cmd,
	input  logic [127:0]                  req_param,
	output logic                          req_done,

	input  logic                          x_ana_done,
	input  logic                          y_ana_done,
	input  fscpu_pkg::img_edge_t          l_edge,
	input  fscpu_pkg::img_edge_t          r_edge,
	input  fscpu_pkg::img_edge_t          x_edge,
	input  fscpu_pkg::img_edge_t          y_edge,

	input  fscpu_pkg::motor_stat_t        ml_stat,
	input  fscpu_pkg::motor_stat_t        mr_stat,
	input  fscpu_pkg::motor_stat_t        mx_stat,
	input  fscpu_pkg::motor_stat_t        my_stat,
	output fscpu_pkg::motor_cmd_t         ml_cmd,
	output fscpu_pkg::motor_cmd_t         mr_cmd,
	output fscpu_pkg::motor_cmd_t         mx_cmd,
	output fscpu_pkg::motor_cmd_t         my_cmd
);
	import fscpu_pkg::*;

	logic             req_en_q;
	fscpu_cmd_e       cmd_q;
	logic [127:0]     par_q;
	logic [31:0]      par0;
	logic [31:0]      par1;
	logic [31:0]      par2;
	logic [31:0]      par3;

	logic [dev_n-1:0] dev_bmp;
	logic [dev_n-1:0] done_bmp;
	logic [dev_n-1:0] seq_rstn;
	logic [1:0]       settle_frm;

	move_req_t        req_a;
	move_req_t        req_b;

	logic [tbl_aw-1:0] bpm_addr_a;
	logic [tbl_aw-1:0] bpm_addr_b;
	logic [step_w-1:0] bpm_q_a;
	logic [step_w-1:0] bpm_q_b;
	logic [tbl_aw-1:0] bam_addr_a;
	logic [tbl_aw-1:0] bam_addr_b;
	logic [step_w-1:0] bam_q_a;
	logic [step_w-1:0] bam_q_b;

	// request capture, decoded one cycle later
	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_en_q <= 1'b0;
		end else begin
			req_en_q <= req_en;
		end
	end

	always_ff @(posedge clk) begin
		if (req_en) begin
			cmd_q <= fscpu_cmd_e'(req_cmd);
			par_q <= req_param;
		end
	end

	assign par0 = par_q[31:0];
	assign par1 = par_q[63:32];
	assign par2 = par_q[95:64];
	assign par3 = par_q[127:96];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dev_bmp    <= '0;
			settle_frm <= '0;
		end else if (req_en_q) begin
			dev_bmp <= '0;
			case (cmd_q)
			cmd_config:     settle_frm <= par0[1:0];
			cmd_lft:        dev_bmp[dev_lft] <= 1'b1;
			cmd_rt:         dev_bmp[dev_rt] <= 1'b1;
			cmd_push_both:  dev_bmp <= (dev_n)'((1 << dev_lft) | (1 << dev_rt));
			cmd_x:          dev_bmp[dev_x] <= 1'b1;
			cmd_y:          dev_bmp[dev_y] <= 1'b1;
			cmd_align_both: dev_bmp <= (dev_n)'((1 << dev_x) | (1 << dev_y));
			default:        dev_bmp <= '0;
			endcase
		end else if (done_bmp == dev_bmp) begin
			// all selected motors finished, release the sequencers
			dev_bmp <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_done <= 1'b0;
		end else if (req_en) begin
			req_done <= 1'b0;
		end else if (done_bmp == dev_bmp && dev_bmp != '0) begin
			req_done <= 1'b1;
		end
	end

	// first motor of a pair uses par2, second uses par3
	assign req_a = '{dep_img: par0[2], dir_back: par0[1], tol: par0[16 +: img_w],
		speed: par1[speed_w-1:0], dst: par2[img_w-1:0], step: par2[step_w-1:0]};
	assign req_b = '{dep_img: par0[2], dir_back: par0[1], tol: par0[16 +: img_w],
		speed: par1[speed_w-1:0], dst: par3[img_w-1:0], step: par3[step_w-1:0]};

	assign seq_rstn = {dev_n{resetn}} & dev_bmp;

	step_table_ram u_bpm (
		.clk(clk), .init(bpm_init), .wr_en(bpm_wr_en), .wr_data(bpm_data),
		.size(bpm_size), .addr_a(bpm_addr_a), .q_a(bpm_q_a),
		.addr_b(bpm_addr_b), .q_b(bpm_q_b)
	);

	step_table_ram u_bam (
		.clk(clk), .init(bam_init), .wr_en(bam_wr_en), .wr_data(bam_data),
		.size(bam_size), .addr_a(bam_addr_a), .q_a(bam_q_a),
		.addr_b(bam_addr_b), .q_b(bam_q_b)
	);

	motor_seq u_seq_lft (
		.clk(clk), .resetn(seq_rstn[dev_lft]), .settle_frm(settle_frm), .req(req_a),
		.img_pulse(x_ana_done), .img_edge(l_edge), .stat(ml_stat),
		.tbl_size(bpm_size), .tbl_q(bpm_q_a),
		.done(done_bmp[dev_lft]), .cmd(ml_cmd), .tbl_addr(bpm_addr_a)
	);

	motor_seq u_seq_rt (
		.clk(clk), .resetn(seq_rstn[dev_rt]), .settle_frm(settle_frm), .req(req_b),
		.img_pulse(x_ana_done), .img_edge(r_edge), .stat(mr_stat),
		.tbl_size(bpm_size), .tbl_q(bpm_q_b),
		.done(done_bmp[dev_rt]), .cmd(mr_cmd), .tbl_addr(bpm_addr_b)
	);

	motor_seq u_seq_x (
		.clk(clk), .resetn(seq_rstn[dev_x]), .settle_frm(settle_frm), .req(req_a),
		.img_pulse(y_ana_done), .img_edge(x_edge), .stat(mx_stat),
		.tbl_size(bam_size), .tbl_q(bam_q_a),
		.done(done_bmp[dev_x]), .cmd(mx_cmd), .tbl_addr(bam_addr_a)
	);

	motor_seq u_seq_y (
		.clk(clk), .resetn(seq_rstn[dev_y]), .settle_frm(settle_frm), .req(req_b),
		.img_pulse(y_ana_done), .img_edge(y_edge), .stat(my_stat),
		.tbl_size(bam_size), .tbl_q(bam_q_b),
		.done(done_bmp[dev_y]), .cmd(my_cmd), .tbl_addr(bam_addr_b)
	);

endmodule

// File: verilog/motor_seq.sv
`timescale 1ns/1ps

module motor_seq (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic [1:0]                    settle_frm,
	input  fscpu_pkg::move_req_t          req,
	input  logic                          img_pulse,
	input  fscpu_pkg::img_edge_t          img_edge,
	input  fscpu_pkg::motor_stat_t        stat,
	input  logic [fscpu_pkg::tbl_aw:0]    tbl_size,
	input  logic [fscpu_pkg::step_w-1:0]  tbl_q,
	output logic                          done,
	output fscpu_pkg::motor_cmd_t         cmd,
	output logic [fscpu_pkg::tbl_aw-1:0]  tbl_addr
);
	import fscpu_pkg::*;

	seq_state_e       state;
	logic             busy_seen;
	logic [1:0]       settle_cnt;

	logic             err_neg;
	logic [img_w-1:0] err_mag;
	logic             in_tol;
	logic [tbl_aw:0]  mag_ext;
	logic [tbl_aw:0]  size_m1;
	logic             tbl_empty;

	// error is dst minus measured position
	assign err_neg = img_edge.pos > req.dst;
	assign err_mag = err_neg ? (img_edge.pos - req.dst) : (req.dst - img_edge.pos);
	assign in_tol  = err_mag <= req.tol;

	// clamp the lookup index to the last loaded entry
	assign mag_ext   = (tbl_aw + 1)'(err_mag);
	assign size_m1   = tbl_size - 1'b1;
	assign tbl_empty = tbl_size == '0;
	assign tbl_addr  = (mag_ext < tbl_size) ? mag_ext[tbl_aw-1:0] : size_m1[tbl_aw-1:0];

	assign done = state == seq_done;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state      <= seq_idle;
			cmd        <= '0;
			busy_seen  <= 1'b0;
			settle_cnt <= '0;
		end else begin
			cmd.start <= 1'b0;
			cmd.stop  <= 1'b0;

			case (state)
			seq_idle: begin
				cmd.speed <= req.speed;
				if (req.dep_img) begin
					state <= seq_wait_img;
				end else begin
					cmd.dir <= req.dir_back;
					state   <= seq_start;
				end
			end

			// open loop, single move of the requested length
			seq_start: begin
				cmd.start <= 1'b1;
				cmd.step  <= req.step;
				busy_seen <= 1'b0;
				state     <= seq_moving;
			end

			seq_wait_img: begin
				if (img_pulse && img_edge.valid) begin
					if (in_tol) begin
						state <= seq_done;
					end else if (tbl_empty) begin
						// no step can be derived, give up without moving
						cmd.stop <= 1'b1;
						state    <= seq_done;
					end else begin
						cmd.dir <= err_neg;
						state   <= seq_lookup;
					end
				end
			end

			// table entry for last cycle's address is on tbl_q
			seq_lookup: begin
				cmd.start <= 1'b1;
				cmd.step  <= tbl_q;
				busy_seen <= 1'b0;
				state     <= seq_moving;
			end

			// wait for busy to rise and fall again
			seq_moving: begin
				if (stat.busy) begin
					busy_seen <= 1'b1;
				end else if (busy_seen) begin
					if (!req.dep_img) begin
						state <= seq_done;
					end else if (settle_frm == 2'd0) begin
						state <= seq_wait_img;
					end else begin
						settle_cnt <= settle_frm;
						state      <= seq_settle;
					end
				end
			end

			// drop frames taken while the mechanics settle
			seq_settle: begin
				if (img_pulse) begin
					settle_cnt <= settle_cnt - 1'b1;
					if (settle_cnt == 2'd1) begin
						state <= seq_wait_img;
					end
				end
			end

			// held until the bitmap bit drops
			seq_done: begin
				state <= seq_done;
			end

			default: begin
				state <= seq_idle;
			end
			endcase
		end
	end

endmodule

// File: verilog/step_table_ram.sv
`timescale 1ns/1ps

module step_table_ram (
	input  logic                          clk,
	input  logic                          init,
	input  logic                          wr_en,
	input  logic [fscpu_pkg::step_w-1:0]  wr_data,
	output logic [fscpu_pkg::tbl_aw:0]    size,
	input  logic [fscpu_pkg::tbl_aw-1:0]  addr_a,
	output logic [fscpu_pkg::step_w-1:0]  q_a,
	input  logic [fscpu_pkg::tbl_aw-1:0]  addr_b,
	output logic [fscpu_pkg::step_w-1:0]  q_b
);
	import fscpu_pkg::*;

	logic [step_w-1:0] mem [tbl_depth];
	logic              full;
	logic              wr_ok;

	// size doubles as the write pointer, top bit set means full
	assign full  = size[tbl_aw];
	assign wr_ok = wr_en && !init && !full;

	always_ff @(posedge clk) begin
		if (init) begin
			size <= '0;
		end else if (wr_ok) begin
			size <= size + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[size[tbl_aw-1:0]] <= wr_data;
		end
	end

	// registered read, one port per motor of the pair
	always_ff @(posedge clk) begin
		q_a <= mem[addr_a];
	end

	always_ff @(posedge clk) begin
		q_b <= mem[addr_b];
	end

endmodule

// File: verilog/fscpu_pkg.sv
package fscpu_pkg;

	// image coordinate and motion widths
	localparam int img_w   = 12;
	localparam int step_w  = 32;
	localparam int speed_w = 32;

	// step table geometry
	localparam int tbl_aw    = 12;
	localparam int tbl_depth = 1 << tbl_aw;

	// device bitmap
	localparam int dev_n   = 4;
	localparam int dev_lft = 0;
	localparam int dev_rt  = 1;
	localparam int dev_x   = 2;
	localparam int dev_y   = 3;

	typedef enum logic [31:0] {
		cmd_config     = 32'd0,
		cmd_lft        = 32'd1,
		cmd_rt         = 32'd2,
		cmd_push_both  = 32'd3,
		cmd_x          = 32'd4,
		cmd_y          = 32'd5,
		cmd_align_both = 32'd6
	} fscpu_cmd_e;

	typedef enum logic [2:0] {
		seq_idle,
		seq_wait_img,
		seq_lookup,
		seq_start,
		seq_moving,
		seq_settle,
		seq_done
	} seq_state_e;

	// controller to motor driver
	typedef struct packed {
		logic               start;
		logic               stop;
		logic [speed_w-1:0] speed;
		logic [step_w-1:0]  step;
		logic               dir;
	} motor_cmd_t;

	// motor driver back to controller
	typedef struct packed {
		logic              zpsign;
		logic              tpsign;
		logic              busy;
		logic [step_w-1:0] position;
	} motor_stat_t;

	typedef struct packed {
		logic             valid;
		logic [img_w-1:0] pos;
	} img_edge_t;

	// one motor's share of a host request
	typedef struct packed {
		logic               dep_img;
		logic               dir_back;
		logic [img_w-1:0]   tol;
		logic [speed_w-1:0] speed;
		logic [img_w-1:0]   dst;
		logic [step_w-1:0]  step;
	} move_req_t;

endpackage
